// ==== verilog.f ====
+incdir+hdl
hdl/seg_disp_pkg.sv
hdl/seg_frame_if.sv
hdl/debug_word_fifo.sv
hdl/digit_scanner.sv
hdl/hc595_serializer.sv
hdl/seg_disp_top.sv
verif/seg_disp_tb.sv

// ==== Bender.yml ====
package:
  name: seg_disp

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/seg_disp_pkg.sv
      - hdl/seg_frame_if.sv
      - hdl/debug_word_fifo.sv
      - hdl/digit_scanner.sv
      - hdl/hc595_serializer.sv
      - hdl/seg_disp_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/seg_disp_tb.sv

// ==== verif/seg_disp_tb.sv ====
`timescale 1ns/10ps
`include "seg_disp_defs.svh"

module seg_disp_tb;
  import seg_disp_pkg::*;

  // debug word and the glyph expected on digit 7
  typedef struct packed {
    debug_word_t word;
    seg_bits_t   top_glyph;
  } table_entry_t;

  localparam int num_words    = 12;
  localparam int frame_cycles = 34 * `SHIFT_DIV;
  // two scans per word plus four scans of margin
  localparam int timeout_cycles = (num_words * 2 * 8 + 4 * 8) * frame_cycles;

  localparam table_entry_t word_table [num_words] = '{
    '{32'h7654_3210, 8'hF8},
    '{32'hFEDC_BA98, 8'h8E},
    '{32'h0000_0000, 8'hC0},
    '{32'hFFFF_FFFF, 8'h8E},
    '{32'h1234_5678, 8'hF9},
    '{32'h9ABC_DEF0, 8'h90},
    '{32'h0F0F_0F0F, 8'hC0},
    '{32'hA5A5_5A5A, 8'h88},
    '{32'h8000_0001, 8'h80},
    '{32'h1357_9BDF, 8'hF9},
    '{32'h2468_ACE0, 8'hA4},
    '{32'hC3E1_D2B4, 8'hC6}
  };

  // reference hex glyphs in active low dp g f e d c b a order
  localparam seg_bits_t glyph_ref [16] = '{
    8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
    8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
  };

  logic        sys_clk = 1'b0;
  logic        rst_n;
  logic        debug_valid;
  debug_word_t debug_word;
  logic        debug_credit;
  logic        segled_clk;
  logic        segled_dat;
  logic        segled_str;

  int          cycles          = 0;
  int          credits_used    = 0;  // words sent
  int          credits_back    = 0;  // debug_credit pulses seen
  int          frame_count     = 0;
  int          scan_idx        = 0;  // 0 is the blank word after reset
  int          prev_scan_idx   = 0;
  int          last_word_scans = 0;
  int          clk_edges       = 0;
  int          str_len         = 0;
  logic [15:0] chain;                // 595 chain model
  logic        prev_clk;
  logic        prev_str;
  logic [15:0] glyph_seen      = '0;
  debug_word_t shown_word      = '0;

  seg_disp_top i_dut (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .debug_valid  (debug_valid),
    .debug_word   (debug_word),
    .debug_credit (debug_credit),
    .segled_clk   (segled_clk),
    .segled_dat   (segled_dat),
    .segled_str   (segled_str)
  );

  always #10 sys_clk = ~sys_clk;

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    $display("error %s: expected %0h, actual %0h", name, expected, actual);
    stop_run();
  endtask

  task automatic plain_error(input string what);
    $display("%s", what);
    stop_run();
  endtask

  // compare one latched frame with the word that the scan must show
  task automatic check_frame(input logic [15:0] bits);
    int      digit;
    nibble_t nib;
    digit = frame_count % 8;
    if (digit == 0) begin
      scan_idx = credits_back;  // one pop per scan start
      assert (scan_idx - prev_scan_idx <= 1 && scan_idx <= num_words)
        else value_error("word order", prev_scan_idx + 1, scan_idx);
      prev_scan_idx = scan_idx;
      shown_word = (scan_idx == 0) ? '0 : word_table[scan_idx - 1].word;
    end
    nib = shown_word[4 * digit +: 4];
    assert (bits[7:0] == dig_sel_t'(1 << digit))
      else value_error($sformatf("digit select %0d", digit), 1 << digit, bits[7:0]);
    assert (bits[15:8] == glyph_ref[nib])
      else value_error($sformatf("glyph digit %0d", digit), glyph_ref[nib], bits[15:8]);
    if (digit == 7 && scan_idx > 0) begin
      assert (bits[15:8] == word_table[scan_idx - 1].top_glyph)
        else value_error("top digit glyph", word_table[scan_idx - 1].top_glyph, bits[15:8]);
    end
    if (shown_word == 32'h7654_3210 || shown_word == 32'hFEDC_BA98) begin
      glyph_seen[nib] = 1'b1;
    end
    if (digit == 7 && scan_idx == num_words) begin
      last_word_scans++;
    end
    frame_count++;
  endtask

  // 595 chain model and serial framing checks
  always @(posedge sys_clk) begin
    if (!rst_n) begin
      prev_clk  = 1'b0;
      prev_str  = 1'b0;
      chain     = '0;
      clk_edges = 0;
      str_len   = 0;
    end else begin
      cycles++;
      if (cycles >= timeout_cycles) begin
        plain_error($sformatf("timeout: display did not finish in %0d cycles", cycles));
      end
      if (debug_credit) begin
        credits_back++;
        assert (credits_back <= credits_used)
          else plain_error("debug_credit returned for a word that was never sent");
      end
      if (segled_clk && !prev_clk) begin
        chain = {chain[14:0], segled_dat};
        clk_edges++;
      end
      if (segled_str) begin
        str_len++;
      end
      if (segled_str && !prev_str) begin
        assert (clk_edges == 16) else value_error("clock edges per frame", 16, clk_edges);
        clk_edges = 0;
        check_frame(chain);
      end
      if (!segled_str && prev_str) begin
        assert (str_len == `SHIFT_DIV) else value_error("strobe length", `SHIFT_DIV, str_len);
        str_len = 0;
      end
      prev_clk = segled_clk;
      prev_str = segled_str;
    end
  end

  initial begin
    int gap;
    void'($urandom(32'h12a2_3106));
    rst_n       = 1'b0;
    debug_valid = 1'b0;
    debug_word  = '0;
    repeat (2) @(negedge sys_clk);
    rst_n = 1'b1;

    repeat (2) begin
      @(negedge sys_clk);
      assert (!segled_clk && !segled_dat && !segled_str && !debug_credit)
        else plain_error("serial outputs or debug_credit high right after reset");
    end

    while (frame_count < 8) @(negedge sys_clk);  // blank scan first

    for (int i = 0; i < num_words; i++) begin
      while (credits_used - credits_back >= `DEBUG_FIFO_DEPTH) @(negedge sys_clk);
      debug_valid = 1'b1;
      debug_word  = word_table[i].word;
      credits_used++;
      @(negedge sys_clk);
      debug_valid = 1'b0;
      debug_word  = '0;
      gap = $urandom_range(4, 0);
      repeat (gap) @(negedge sys_clk);
    end

    // last word once, then two repeats from the empty fifo
    while (last_word_scans < 3) @(negedge sys_clk);

    assert (credits_back == credits_used)
      else value_error("debug_credit pulses", credits_used, credits_back);
    assert (glyph_seen == 16'hFFFF) else value_error("hex values shown", 16'hFFFF, glyph_seen);
    $display("TEST OK");
    $finish;
  end

endmodule

// ==== hdl/seg_disp_top.sv ====
`timescale 1ns/10ps

module seg_disp_top (
  input  logic                      sys_clk,
  input  logic                      rst_n,
  input  logic                      debug_valid,
  input  seg_disp_pkg::debug_word_t debug_word,
  output logic                      debug_credit,
  output logic                      segled_clk,
  output logic                      segled_dat,
  output logic                      segled_str
);
  import seg_disp_pkg::*;

  logic        word_avail;
  logic        word_pop;
  debug_word_t word_head;

  seg_frame_if frame_bus ();  // scanner to serializer

  debug_word_fifo u_fifo (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .debug_valid  (debug_valid),
    .debug_word   (debug_word),
    .word_pop     (word_pop),
    .word_avail   (word_avail),
    .word_head    (word_head),
    .debug_credit (debug_credit)
  );

  digit_scanner u_scanner (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .word_avail (word_avail),
    .word_head  (word_head),
    .word_pop   (word_pop),
    .frame      (frame_bus.source)
  );

  hc595_serializer u_serializer (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .frame      (frame_bus.sink),
    .segled_clk (segled_clk),
    .segled_dat (segled_dat),
    .segled_str (segled_str)
  );

endmodule

// ==== hdl/hc595_serializer.sv ====
`timescale 1ns/10ps
`include "seg_disp_defs.svh"

module hc595_serializer (
  input  logic      sys_clk,
  input  logic      rst_n,
  seg_frame_if.sink frame,
  output logic      segled_clk,
  output logic      segled_dat,
  output logic      segled_str
);
  import seg_disp_pkg::*;

  ser_state_e  state;
  frame_bits_t hold_bits;   // second frame waits here
  frame_bits_t shift_bits;
  logic        hold_full;
  logic [3:0]  bit_cnt;     // 16 bits per frame
  logic [$clog2(`SHIFT_DIV+1)-1:0] div_cnt;
  logic        div_done;

  assign div_done = (div_cnt == `SHIFT_DIV - 1);

  always_ff @(posedge sys_clk) begin
    if (frame.frame_valid) begin
      hold_bits <= {frame.seg_bits, frame.dig_sel};
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      state              <= IDLE;
      hold_full          <= 1'b0;
      bit_cnt            <= '0;
      div_cnt            <= '0;
      segled_clk         <= 1'b0;
      segled_dat         <= 1'b0;
      segled_str         <= 1'b0;
      frame.frame_credit <= 1'b0;
    end else begin
      frame.frame_credit <= 1'b0;

      case (state)
        IDLE: begin
          if (hold_full) begin
            shift_bits <= hold_bits;
            hold_full  <= 1'b0;
            segled_dat <= hold_bits[15];  // segment msb goes out first
            bit_cnt    <= '0;
            div_cnt    <= '0;
            state      <= SHIFT_LO;
          end
        end
        SHIFT_LO: begin
          div_cnt <= div_cnt + 1'b1;
          if (div_done) begin
            div_cnt    <= '0;
            segled_clk <= 1'b1;  // 595 samples on this edge
            state      <= SHIFT_HI;
          end
        end
        SHIFT_HI: begin
          div_cnt <= div_cnt + 1'b1;
          if (div_done) begin
            div_cnt    <= '0;
            segled_clk <= 1'b0;
            if (bit_cnt == 4'd15) begin
              segled_dat <= 1'b0;
              segled_str <= 1'b1;
              state      <= STROBE;
            end else begin
              bit_cnt    <= bit_cnt + 1'b1;
              shift_bits <= shift_bits << 1;
              segled_dat <= shift_bits[14];
              state      <= SHIFT_LO;
            end
          end
        end
        STROBE: begin
          div_cnt <= div_cnt + 1'b1;
          if (div_done) begin
            div_cnt            <= '0;
            segled_str         <= 1'b0;
            frame.frame_credit <= 1'b1;  // frame latched, slot is free
            state              <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase

      // a frame arriving while the holding register empties still lands
      if (frame.frame_valid) begin
        hold_full <= 1'b1;
      end
    end
  end

  // the scanner's credits must cover holding plus shift register
  a_no_overrun: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    frame.frame_valid |-> !(hold_full && state != IDLE)
  ) else $error("frame arrived with both buffers occupied");

  a_str_clk_apart: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    !(segled_str && segled_clk)
  ) else $error("strobe and serial clock high together");

endmodule

// ==== hdl/digit_scanner.sv ====
`timescale 1ns/10ps
`include "seg_disp_defs.svh"

module digit_scanner (
  input  logic                      sys_clk,
  input  logic                      rst_n,
  input  logic                      word_avail,
  input  seg_disp_pkg::debug_word_t word_head,
  output logic                      word_pop,
  seg_frame_if.source               frame
);
  import seg_disp_pkg::*;

  debug_word_t cur_word;   // word shown by the running scan
  debug_word_t scan_word;
  digit_idx_t  digit;
  nibble_t     nib;
  dig_sel_t    sel;
  logic        issue;

  // one spare bit so an overflow shows up instead of wrapping
  logic [$clog2(`FRAME_CREDITS+1):0] credits;

  // hex glyphs, segment on = 0, dp always dark
  function automatic seg_bits_t hex_glyph(input nibble_t value);
    case (value)
      4'h0:    return 8'hC0;
      4'h1:    return 8'hF9;
      4'h2:    return 8'hA4;
      4'h3:    return 8'hB0;
      4'h4:    return 8'h99;
      4'h5:    return 8'h92;
      4'h6:    return 8'h82;
      4'h7:    return 8'hF8;
      4'h8:    return 8'h80;
      4'h9:    return 8'h90;
      4'hA:    return 8'h88;
      4'hB:    return 8'h83;  // lower case b
      4'hC:    return 8'hC6;
      4'hD:    return 8'hA1;  // lower case d
      4'hE:    return 8'h86;
      default: return 8'h8E;
    endcase
  endfunction

  assign issue = (credits != '0);

  // a new word is taken only at the start of a scan
  assign scan_word = (digit == '0 && word_avail) ? word_head : cur_word;
  assign nib       = scan_word[{digit, 2'b00} +: 4];
  assign sel       = dig_sel_t'(1) << digit;

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      credits <= `FRAME_CREDITS;
    end else begin
      case ({issue, frame.frame_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // spent and returned in one cycle
      endcase
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      digit             <= '0;
      cur_word          <= '0;  // blank scan shows zeros
      word_pop          <= 1'b0;
      frame.frame_valid <= 1'b0;
    end else begin
      frame.frame_valid <= issue;
      word_pop          <= issue && (digit == '0) && word_avail;
      if (issue) begin
        digit <= digit + 1'b1;  // wraps from 7 back to 0
        if (digit == '0) begin
          cur_word <= scan_word;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (issue) begin
      frame.seg_bits <= hex_glyph(nib);
      frame.dig_sel  <= sel;
    end
  end

  // serializer returns no more credits than frames it was sent
  a_credit_bound: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    credits <= `FRAME_CREDITS
  ) else $error("frame credit counter above its limit");

endmodule

// ==== hdl/debug_word_fifo.sv ====
`timescale 1ns/10ps
`include "seg_disp_defs.svh"

module debug_word_fifo (
  input  logic                      sys_clk,
  input  logic                      rst_n,
  input  logic                      debug_valid,
  input  seg_disp_pkg::debug_word_t debug_word,
  input  logic                      word_pop,
  output logic                      word_avail,
  output seg_disp_pkg::debug_word_t word_head,
  output logic                      debug_credit
);
  import seg_disp_pkg::*;

  debug_word_t mem [`DEBUG_FIFO_DEPTH];

  logic [$clog2(`DEBUG_FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(`DEBUG_FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(`DEBUG_FIFO_DEPTH+1)-1:0] count;

  // wraps also for depths that are not a power of two
  function automatic logic [$clog2(`DEBUG_FIFO_DEPTH)-1:0] next_ptr(
    input logic [$clog2(`DEBUG_FIFO_DEPTH)-1:0] ptr
  );
    if (ptr == `DEBUG_FIFO_DEPTH - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge sys_clk) begin
    if (debug_valid) begin
      mem[wr_ptr] <= debug_word;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      debug_credit <= 1'b0;
    end else begin
      debug_credit <= word_pop;  // one credit back per popped word

      if (debug_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (word_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end

      case ({debug_valid, word_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or write and pop together
      endcase
    end
  end

  assign word_avail = (count != '0);
  assign word_head  = mem[rd_ptr];  // head is valid the cycle after the write

  // the sender must not spend more credits than it was given
  a_no_write_full: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    debug_valid |-> (count != `DEBUG_FIFO_DEPTH)
  ) else $error("debug word written while fifo full");

  // scanner pops only what it saw as available
  a_no_pop_empty: assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    word_pop |-> (count != '0)
  ) else $error("debug word popped while fifo empty");

endmodule

// ==== hdl/seg_frame_if.sv ====
`timescale 1ns/10ps

interface seg_frame_if;
  import seg_disp_pkg::*;

  logic      frame_valid;   // one cycle per frame, costs one credit
  seg_bits_t seg_bits;
  dig_sel_t  dig_sel;
  logic      frame_credit;  // one cycle pulse, returns one credit

  modport source (
    output frame_valid,
    output seg_bits,
    output dig_sel,
    input  frame_credit
  );

  modport sink (
    input  frame_valid,
    input  seg_bits,
    input  dig_sel,
    output frame_credit
  );

endinterface

// ==== hdl/seg_disp_pkg.sv ====
package seg_disp_pkg;

  typedef logic [31:0] debug_word_t;  // one word from the cpu side
  typedef logic [3:0] nibble_t;       // one hex digit
  typedef logic [7:0] seg_bits_t;     // dp,g,f,e,d,c,b,a; active low
  typedef logic [7:0] dig_sel_t;      // one-hot, active high
  typedef logic [2:0] digit_idx_t;

  // segment byte followed by digit select, as shifted into the 595 chain
  typedef logic [15:0] frame_bits_t;

  typedef enum logic [1:0] {
    IDLE,
    SHIFT_LO,  // data set up, serial clock low
    SHIFT_HI,  // serial clock high
    STROBE     // latch pulse to the 595 outputs
  } ser_state_e;

endpackage

// ==== hdl/seg_disp_defs.svh ====
`ifndef SEG_DISP_DEFS_SVH
`define SEG_DISP_DEFS_SVH

// debug word entries, also the sender's initial credit count
`define DEBUG_FIFO_DEPTH 4

// frames the serializer takes before a credit comes back
`define FRAME_CREDITS 2

// sys_clk cycles per half period of segled_clk
`define SHIFT_DIV 4

`endif
